// File: logic/nandCommandPkg.sv
`default_nettype none

package nandCommandPkg;

    typedef logic [5:0]  opcodeT;
    typedef logic [4:0]  targetIdT;
    typedef logic [31:0] hostAddressT;
    typedef logic [15:0] dataLengthT;
    typedef logic [15:0] columnAddressT;
    typedef logic [23:0] rowAddressT;
    typedef logic [39:0] caDataT;
    typedef logic [7:0]  atomCommandT;   // Zero means no request.

    typedef enum logic [1:0] {
        ExecutorIdle,
        ExecutorIssue,
        ExecutorWaitLast,
        ExecutorWaitWay
    } executorStateT;

    localparam targetIdT AddressTargetId = 5'd4;
    localparam targetIdT CommandTargetId = 5'd5;

    // Opcodes of the address target.
    localparam opcodeT WaySelectOpcode = 6'd0;
    localparam opcodeT ColumnOpcode    = 6'd2;
    localparam opcodeT RowOpcode       = 6'd4;

    localparam opcodeT ResetOpcode   = 6'd1;
    localparam opcodeT ProgramOpcode = 6'd3;
    localparam opcodeT ReadOpcode    = 6'd4;
    localparam opcodeT EraseOpcode   = 6'd6;

    localparam int NumberOfCommands = 4;

    // Command index order is reset, program, read, erase.
    localparam opcodeT CommandOpcodeTable [NumberOfCommands] =
        '{ResetOpcode, ProgramOpcode, ReadOpcode, EraseOpcode};
    localparam atomCommandT AtomCommandTable [NumberOfCommands] =
        '{8'h01, 8'h02, 8'h04, 8'h08};

    localparam logic [NumberOfCommands-1:0] UsesAddressTable = 4'b1110;
    localparam logic [NumberOfCommands-1:0] UsesLengthTable  = 4'b0110;   // Page transfers only.

    localparam atomCommandT IdleAtomCommand = '0;

endpackage

`default_nettype wire

// File: logic/commandDispatcher.sv
`default_nettype none

module commandDispatcher #(
    parameter int NumberOfWays = 4
) (
    input  wire logic                                          iSystemClock,
    input  wire logic                                          iReset,
    input  wire nandCommandPkg::opcodeT                        iOpcode,
    input  wire nandCommandPkg::targetIdT                      iTargetId,
    input  wire nandCommandPkg::hostAddressT                   iAddress,
    input  wire logic                                          iCommandValid,
    input  wire logic                                          iCommandReady,
    output logic [nandCommandPkg::NumberOfCommands-1:0]        startPulse,
    output logic [NumberOfWays-1:0]                            waySelect,
    output nandCommandPkg::columnAddressT                      columnAddress,
    output nandCommandPkg::rowAddressT                         rowAddress
);

    import nandCommandPkg::*;

    logic accepted;
    logic addressWrite;
    logic commandWrite;

    assign accepted     = iCommandValid && iCommandReady;
    assign addressWrite = accepted && (iTargetId == AddressTargetId);
    assign commandWrite = accepted && (iTargetId == CommandTargetId);

    // Address registers take the new value at the acceptance edge.
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            waySelect     <= '0;
            columnAddress <= '0;
            rowAddress    <= '0;
        end else if (addressWrite) begin
            case (iOpcode)
                WaySelectOpcode: begin
                    waySelect <= iAddress[NumberOfWays-1:0];
                end
                ColumnOpcode: begin
                    columnAddress <= iAddress[15:0];
                end
                RowOpcode: begin
                    rowAddress <= iAddress[23:0];
                end
                default: begin
                    waySelect <= waySelect;   // Unknown address opcode is dropped.
                end
            endcase
        end
    end

    // One start line per executor, matched against the opcode table.
    always_comb begin
        for (int k = 0; k < NumberOfCommands; k++) begin
            startPulse[k] = commandWrite && (iOpcode == CommandOpcodeTable[k]);
        end
    end

    startPulseOneHot: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        $onehot0(startPulse)
    ) else $error("More than one executor started by a single command.");

endmodule

`default_nettype wire

// File: logic/commandExecutor.sv
`default_nettype none

module commandExecutor #(
    parameter int NumberOfWays = 4,
    parameter int CommandIndex = 0
) (
    input  wire logic                            iSystemClock,
    input  wire logic                            iReset,
    input  wire logic                            startPulse,
    input  wire logic [NumberOfWays-1:0]         waySelect,
    input  wire nandCommandPkg::columnAddressT   columnAddress,
    input  wire nandCommandPkg::rowAddressT      rowAddress,
    input  wire nandCommandPkg::dataLengthT      iLength,
    input  wire logic                            iAcgReady,
    input  wire logic                            iAcgLastStep,
    input  wire logic [NumberOfWays-1:0]         iAcgReadyBusy,
    output logic                                 active,
    output nandCommandPkg::atomCommandT          atomCommand,
    output logic [NumberOfWays-1:0]              targetWay,
    output nandCommandPkg::dataLengthT           numOfData,
    output logic                                 caSelect,
    output nandCommandPkg::caDataT               caData
);

    import nandCommandPkg::*;

    executorStateT state;
    executorStateT nextState;

    logic [NumberOfWays-1:0] wayLatched;
    columnAddressT           columnLatched;
    rowAddressT              rowLatched;
    dataLengthT              lengthLatched;
    caDataT                  requestCaData;
    logic                    wayReady;

    assign wayReady = |(iAcgReadyBusy & wayLatched);

    always_comb begin
        nextState = state;
        case (state)
            ExecutorIdle: begin
                if (startPulse) begin
                    nextState = ExecutorIssue;
                end
            end
            ExecutorIssue: begin
                if (iAcgReady) begin
                    nextState = ExecutorWaitLast;   // ACG took the request.
                end
            end
            ExecutorWaitLast: begin
                if (iAcgLastStep) begin
                    nextState = ExecutorWaitWay;
                end
            end
            default: begin
                if (wayReady) begin
                    nextState = ExecutorIdle;
                end
            end
        endcase
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            state <= ExecutorIdle;
        end else begin
            state <= nextState;
        end
    end

    // Operation fields are captured together with the start.
    always_ff @(posedge iSystemClock) begin
        if (startPulse) begin
            wayLatched    <= waySelect;
            columnLatched <= columnAddress;
            rowLatched    <= rowAddress;
            lengthLatched <= iLength;
        end
    end

    always_comb begin
        requestCaData = '0;
        if (UsesAddressTable[CommandIndex] && UsesLengthTable[CommandIndex]) begin
            requestCaData = {rowLatched, columnLatched};
        end else if (UsesAddressTable[CommandIndex]) begin
            requestCaData = caDataT'(rowLatched);   // Block address only.
        end
    end

    assign active = (state != ExecutorIdle);

    always_comb begin
        atomCommand = IdleAtomCommand;
        targetWay   = '0;
        numOfData   = '0;
        caSelect    = 1'b0;
        caData      = '0;
        if (state == ExecutorIssue) begin
            atomCommand = AtomCommandTable[CommandIndex];
            targetWay   = wayLatched;
            numOfData   = UsesLengthTable[CommandIndex] ? lengthLatched : dataLengthT'(0);
            caSelect    = UsesAddressTable[CommandIndex];
            caData      = requestCaData;
        end
    end

    // Host ready must keep new commands away while this one runs.
    startOnlyWhenIdle: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        startPulse |-> (state == ExecutorIdle)
    ) else $error("Executor %0d started while busy.", CommandIndex);

    latchedWayOneHot: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        (state != ExecutorIdle) |-> $onehot(wayLatched)
    ) else $error("Executor %0d runs without a single selected way.", CommandIndex);

endmodule

`default_nettype wire

// File: logic/atomCommandMux.sv
`default_nettype none

module atomCommandMux #(
    parameter int NumberOfWays = 4
) (
    input  wire logic [nandCommandPkg::NumberOfCommands-1:0] active,
    input  wire nandCommandPkg::atomCommandT
        atomCommand [nandCommandPkg::NumberOfCommands],
    input  wire logic [NumberOfWays-1:0]
        targetWay [nandCommandPkg::NumberOfCommands],
    input  wire nandCommandPkg::dataLengthT
        numOfData [nandCommandPkg::NumberOfCommands],
    input  wire logic [nandCommandPkg::NumberOfCommands-1:0] caSelect,
    input  wire nandCommandPkg::caDataT
        caData [nandCommandPkg::NumberOfCommands],
    output nandCommandPkg::atomCommandT                      oAcgCommand,
    output logic [NumberOfWays-1:0]                          oAcgTargetWay,
    output nandCommandPkg::dataLengthT                       oAcgNumOfData,
    output logic                                             oAcgCaSelect,
    output nandCommandPkg::caDataT                           oAcgCaData,
    output logic                                             commandReady
);

    import nandCommandPkg::*;

    // At most one executor runs, so a priority loop is enough.
    always_comb begin
        oAcgCommand   = IdleAtomCommand;
        oAcgTargetWay = '0;
        oAcgNumOfData = '0;
        oAcgCaSelect  = 1'b0;
        oAcgCaData    = '0;
        for (int k = 0; k < NumberOfCommands; k++) begin
            if (active[k]) begin
                oAcgCommand   = atomCommand[k];
                oAcgTargetWay = targetWay[k];
                oAcgNumOfData = numOfData[k];
                oAcgCaSelect  = caSelect[k];
                oAcgCaData    = caData[k];
            end
        end
    end

    assign commandReady = ~|active;   // Host may send while all executors idle.

    // Executor states are unknown until the first reset.
    activeOneHot: assert final ($isunknown(active) || $onehot0(active))
        else $error("Several executors active at once: %b.", active);

endmodule

`default_nettype wire

// File: logic/nandCommandIssue.sv
`default_nettype none

module nandCommandIssue #(
    parameter int NumberOfWays = 4
) (
    input  wire logic                            iSystemClock,
    input  wire logic                            iReset,
    input  wire nandCommandPkg::opcodeT          iOpcode,
    input  wire nandCommandPkg::targetIdT        iTargetId,
    input  wire nandCommandPkg::hostAddressT     iAddress,
    input  wire nandCommandPkg::dataLengthT      iLength,
    input  wire logic                            iCommandValid,
    output logic                                 oCommandReady,
    output nandCommandPkg::atomCommandT          oAcgCommand,
    output logic [NumberOfWays-1:0]              oAcgTargetWay,
    output nandCommandPkg::dataLengthT           oAcgNumOfData,
    output logic                                 oAcgCaSelect,
    output nandCommandPkg::caDataT               oAcgCaData,
    input  wire logic                            iAcgReady,
    input  wire logic                            iAcgLastStep,
    input  wire logic [NumberOfWays-1:0]         iAcgReadyBusy,
    output logic [NumberOfWays-1:0]              oReadyBusy
);

    import nandCommandPkg::*;

    wire [NumberOfCommands-1:0] startPulse;
    wire [NumberOfWays-1:0]     waySelect;
    wire columnAddressT         columnAddress;
    wire rowAddressT            rowAddress;

    wire [NumberOfCommands-1:0] executorActive;
    wire atomCommandT           executorCommand [NumberOfCommands];
    wire [NumberOfWays-1:0]     executorTargetWay [NumberOfCommands];
    wire dataLengthT            executorNumOfData [NumberOfCommands];
    wire [NumberOfCommands-1:0] executorCaSelect;
    wire caDataT                executorCaData [NumberOfCommands];

    assign oReadyBusy = iAcgReadyBusy;

    commandDispatcher #(
        .NumberOfWays (NumberOfWays)
    ) dispatcher (
        .iSystemClock  (iSystemClock),
        .iReset        (iReset),
        .iOpcode       (iOpcode),
        .iTargetId     (iTargetId),
        .iAddress      (iAddress),
        .iCommandValid (iCommandValid),
        .iCommandReady (oCommandReady),
        .startPulse    (startPulse),
        .waySelect     (waySelect),
        .columnAddress (columnAddress),
        .rowAddress    (rowAddress)
    );

    // One executor per flash operation, in command index order.
    for (genvar k = 0; k < NumberOfCommands; k++) begin : gExecutor
        commandExecutor #(
            .NumberOfWays (NumberOfWays),
            .CommandIndex (k)
        ) executor (
            .iSystemClock  (iSystemClock),
            .iReset        (iReset),
            .startPulse    (startPulse[k]),
            .waySelect     (waySelect),
            .columnAddress (columnAddress),
            .rowAddress    (rowAddress),
            .iLength       (iLength),
            .iAcgReady     (iAcgReady),
            .iAcgLastStep  (iAcgLastStep),
            .iAcgReadyBusy (iAcgReadyBusy),
            .active        (executorActive[k]),
            .atomCommand   (executorCommand[k]),
            .targetWay     (executorTargetWay[k]),
            .numOfData     (executorNumOfData[k]),
            .caSelect      (executorCaSelect[k]),
            .caData        (executorCaData[k])
        );
    end

    atomCommandMux #(
        .NumberOfWays (NumberOfWays)
    ) mux (
        .active        (executorActive),
        .atomCommand   (executorCommand),
        .targetWay     (executorTargetWay),
        .numOfData     (executorNumOfData),
        .caSelect      (executorCaSelect),
        .caData        (executorCaData),
        .oAcgCommand   (oAcgCommand),
        .oAcgTargetWay (oAcgTargetWay),
        .oAcgNumOfData (oAcgNumOfData),
        .oAcgCaSelect  (oAcgCaSelect),
        .oAcgCaData    (oAcgCaData),
        .commandReady  (oCommandReady)
    );

endmodule

`default_nettype wire

// File: tb/acgModel.sv
`default_nettype none

module acgModel #(
    parameter int          NumberOfWays = 4,
    parameter logic [31:0] Seed         = 32'h7183_2cd2
) (
    input  wire logic                          iSystemClock,
    input  wire logic                          iReset,
    input  wire nandCommandPkg::atomCommandT   command,
    input  wire logic [NumberOfWays-1:0]       targetWay,
    output logic                               acgReady,
    output logic                               lastStep,
    output logic [NumberOfWays-1:0]            readyBusy
);

    import nandCommandPkg::*;

    logic [31:0]             randomState;
    logic [NumberOfWays-1:0] wayHeld;

    function automatic logic [31:0] nextRandom();
        randomState = randomState * 32'd1664525 + 32'd1013904223;
        return randomState ^ (randomState >> 16);
    endfunction

    // Each wait ends one time unit after a rising edge.
    task automatic waitCycles(input int count);
        repeat (count) begin
            @(posedge iSystemClock);
            #1;
        end
    endtask

    initial begin
        randomState = Seed;
        acgReady    = 1'b0;
        lastStep    = 1'b0;
        readyBusy   = '1;   // All ways start ready.
        wayHeld     = '0;
        @(negedge iReset);
        forever begin
            waitCycles(1);
            if (command != IdleAtomCommand) begin
                wayHeld = targetWay;
                waitCycles(nextRandom() % 4);   // Back-pressure.
                acgReady = 1'b1;
                waitCycles(1);
                acgReady = 1'b0;
                waitCycles(nextRandom() % 4);
                lastStep  = 1'b1;
                readyBusy = readyBusy & ~wayHeld;   // Way turns busy with the last step.
                waitCycles(1);
                lastStep = 1'b0;
                waitCycles(nextRandom() % 5);
                readyBusy = '1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/nandCommandIssueTb.sv
`default_nettype none

module nandCommandIssueTb;

    import nandCommandPkg::*;

    localparam int NumberOfWays     = 4;
    localparam int ClockPeriod      = 8;
    localparam int ResetCycles      = 8;
    localparam int DirectedCount    = 7;
    localparam int RandomCount      = 80;
    localparam int CommandCount     = DirectedCount + RandomCount;
    localparam int CyclesPerCommand = 200;

    logic                    iSystemClock;
    logic                    iReset;
    opcodeT                  iOpcode;
    targetIdT                iTargetId;
    hostAddressT             iAddress;
    dataLengthT              iLength;
    logic                    iCommandValid;
    logic                    oCommandReady;
    atomCommandT             oAcgCommand;
    logic [NumberOfWays-1:0] oAcgTargetWay;
    dataLengthT              oAcgNumOfData;
    logic                    oAcgCaSelect;
    caDataT                  oAcgCaData;
    logic                    iAcgReady;
    logic                    iAcgLastStep;
    logic [NumberOfWays-1:0] iAcgReadyBusy;
    logic [NumberOfWays-1:0] oReadyBusy;

    logic [31:0]             randomState;
    int                      failureCount;
    int                      acceptedIndex;
    logic                    flashAccepted;
    logic [NumberOfWays-1:0] refWay;
    columnAddressT           refColumn;
    rowAddressT              refRow;
    atomCommandT             expectedCommand;
    logic [NumberOfWays-1:0] expectedWay;
    dataLengthT              expectedNumOfData;
    logic                    expectedCaSelect;
    caDataT                  expectedCaData;
    logic                    requestPending;   // Accepted but not yet taken by the ACG.
    logic                    commandBusy;
    logic                    lastStepSeen;

    nandCommandIssue #(
        .NumberOfWays (NumberOfWays)
    ) UUT (
        .iSystemClock  (iSystemClock),
        .iReset        (iReset),
        .iOpcode       (iOpcode),
        .iTargetId     (iTargetId),
        .iAddress      (iAddress),
        .iLength       (iLength),
        .iCommandValid (iCommandValid),
        .oCommandReady (oCommandReady),
        .oAcgCommand   (oAcgCommand),
        .oAcgTargetWay (oAcgTargetWay),
        .oAcgNumOfData (oAcgNumOfData),
        .oAcgCaSelect  (oAcgCaSelect),
        .oAcgCaData    (oAcgCaData),
        .iAcgReady     (iAcgReady),
        .iAcgLastStep  (iAcgLastStep),
        .iAcgReadyBusy (iAcgReadyBusy),
        .oReadyBusy    (oReadyBusy)
    );

    acgModel #(
        .NumberOfWays (NumberOfWays),
        .Seed         (32'h7183_2cd2)
    ) acg (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .command      (oAcgCommand),
        .targetWay    (oAcgTargetWay),
        .acgReady     (iAcgReady),
        .lastStep     (iAcgLastStep),
        .readyBusy    (iAcgReadyBusy)
    );

    always #(ClockPeriod / 2) iSystemClock = ~iSystemClock;

    function automatic logic [31:0] nextRandom();
        randomState = randomState * 32'd1664525 + 32'd1013904223;
        return randomState ^ (randomState >> 16);
    endfunction

    function automatic int commandIndexOf(input opcodeT opcode);
        int index;
        index = -1;
        for (int k = 0; k < NumberOfCommands; k++) begin
            if (CommandOpcodeTable[k] == opcode) begin
                index = k;
            end
        end
        return index;
    endfunction

    // Page commands carry row and column, erase carries the block row only.
    function automatic caDataT caDataFor(input opcodeT opcode, input rowAddressT row,
                                         input columnAddressT column);
        caDataT value;
        case (opcode)
            ProgramOpcode, ReadOpcode: value = {row, column};
            EraseOpcode:               value = {16'h0000, row};
            default:                   value = '0;
        endcase
        return value;
    endfunction

    task automatic stopWithFailure(input string reason);
        failureCount++;
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic sendCommand(input targetIdT target, input opcodeT opcode,
                               input hostAddressT address, input dataLengthT length);
        iTargetId     = target;
        iOpcode       = opcode;
        iAddress      = address;
        iLength       = length;
        iCommandValid = 1'b1;
        while (!oCommandReady) begin   // Fields stay put until ready.
            @(posedge iSystemClock);
            #1;
        end
        @(posedge iSystemClock);
        #1;
        iCommandValid = 1'b0;
    endtask

    assign acceptedIndex = commandIndexOf(iOpcode);
    assign flashAccepted = iCommandValid && oCommandReady && (iTargetId == CommandTargetId)
                           && (acceptedIndex >= 0);

    always @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            refWay            <= '0;
            refColumn         <= '0;
            refRow            <= '0;
            expectedCommand   <= '0;
            expectedWay       <= '0;
            expectedNumOfData <= '0;
            expectedCaSelect  <= 1'b0;
            expectedCaData    <= '0;
            requestPending    <= 1'b0;
            commandBusy       <= 1'b0;
            lastStepSeen      <= 1'b0;
        end else if (flashAccepted) begin
            expectedCommand   <= AtomCommandTable[acceptedIndex];
            expectedWay       <= refWay;
            expectedNumOfData <= UsesLengthTable[acceptedIndex] ? iLength : dataLengthT'(0);
            expectedCaSelect  <= UsesAddressTable[acceptedIndex];
            expectedCaData    <= caDataFor(iOpcode, refRow, refColumn);
            requestPending    <= 1'b1;
            commandBusy       <= 1'b1;
            lastStepSeen      <= 1'b0;
        end else begin
            if (iCommandValid && oCommandReady && (iTargetId == AddressTargetId)) begin
                case (iOpcode)
                    WaySelectOpcode: refWay    <= iAddress[NumberOfWays-1:0];
                    ColumnOpcode:    refColumn <= iAddress[15:0];
                    RowOpcode:       refRow    <= iAddress[23:0];
                    default:         refRow    <= refRow;
                endcase
            end
            if (requestPending && iAcgReady) begin
                requestPending <= 1'b0;
            end
            if (commandBusy && !requestPending && iAcgLastStep) begin
                lastStepSeen <= 1'b1;
            end
            if (commandBusy && lastStepSeen && |(iAcgReadyBusy & expectedWay)) begin
                commandBusy <= 1'b0;
            end
        end
    end

    readyAfterReset: assert property (@(posedge iSystemClock)
        $fell(iReset) |-> oCommandReady && (oAcgCommand == '0) && !oAcgCaSelect)
        else stopWithFailure($sformatf(
            "** Error: after reset oCommandReady %h, oAcgCommand %h, oAcgCaSelect %h",
            $sampled(oCommandReady), $sampled(oAcgCommand), $sampled(oAcgCaSelect)));

    firstRequest: assert property (@(posedge iSystemClock) disable iff (iReset)
        flashAccepted |=> (oAcgCommand == expectedCommand))
        else stopWithFailure($sformatf("** Error: oAcgCommand expected %h, got %h",
            $sampled(expectedCommand), $sampled(oAcgCommand)));

    requestCommand: assert property (@(posedge iSystemClock) disable iff (iReset)
        (oAcgCommand != '0) |-> (oAcgCommand == expectedCommand) && requestPending)
        else stopWithFailure($sformatf("** Error: oAcgCommand expected %h, got %h",
            $sampled(requestPending) ? $sampled(expectedCommand) : 8'h00,
            $sampled(oAcgCommand)));

    requestWay: assert property (@(posedge iSystemClock) disable iff (iReset)
        (oAcgCommand != '0) |-> (oAcgTargetWay == expectedWay))
        else stopWithFailure($sformatf("** Error: oAcgTargetWay expected %h, got %h",
            $sampled(expectedWay), $sampled(oAcgTargetWay)));

    requestNumOfData: assert property (@(posedge iSystemClock) disable iff (iReset)
        (oAcgCommand != '0) |-> (oAcgNumOfData == expectedNumOfData))
        else stopWithFailure($sformatf("** Error: oAcgNumOfData expected %h, got %h",
            $sampled(expectedNumOfData), $sampled(oAcgNumOfData)));

    requestCaSelect: assert property (@(posedge iSystemClock) disable iff (iReset)
        (oAcgCommand != '0) |-> (oAcgCaSelect == expectedCaSelect))
        else stopWithFailure($sformatf("** Error: oAcgCaSelect expected %h, got %h",
            $sampled(expectedCaSelect), $sampled(oAcgCaSelect)));

    requestCaData: assert property (@(posedge iSystemClock) disable iff (iReset)
        (oAcgCommand != '0) |-> (oAcgCaData == expectedCaData))
        else stopWithFailure($sformatf("** Error: oAcgCaData expected %h, got %h",
            $sampled(expectedCaData), $sampled(oAcgCaData)));

    // Held request must not move while the ACG stalls.
    requestStable: assert property (@(posedge iSystemClock) disable iff (iReset)
        (oAcgCommand != '0) && !iAcgReady |=> $stable(oAcgCommand) && $stable(oAcgTargetWay)
        && $stable(oAcgNumOfData) && $stable(oAcgCaSelect) && $stable(oAcgCaData))
        else stopWithFailure("Request changed while the ACG held its ready low.");

    readyMatchesBusy: assert property (@(posedge iSystemClock) disable iff (iReset)
        oCommandReady == !commandBusy)
        else stopWithFailure($sformatf("** Error: oCommandReady expected %h, got %h",
            !$sampled(commandBusy), $sampled(oCommandReady)));

    readyBusyForwarded: assert property (@(posedge iSystemClock) disable iff (iReset)
        oReadyBusy == iAcgReadyBusy)
        else stopWithFailure($sformatf("** Error: oReadyBusy expected %h, got %h",
            $sampled(iAcgReadyBusy), $sampled(oReadyBusy)));

    initial begin
        repeat (ResetCycles + CyclesPerCommand * CommandCount) @(posedge iSystemClock);
        stopWithFailure("Watchdog expired before the command stream finished.");
    end

    initial begin
        int                      choice;
        hostAddressT             word;
        dataLengthT              length;
        targetIdT                target;
        opcodeT                  opcode;
        logic [NumberOfWays-1:0] oneHotWay;
        randomState   = 32'h7183_2cd2;
        failureCount  = 0;
        iSystemClock  = 1'b0;
        iReset        = 1'b1;
        iOpcode       = '0;
        iTargetId     = '0;
        iAddress      = '0;
        iLength       = '0;
        iCommandValid = 1'b0;
        repeat (ResetCycles) @(posedge iSystemClock);
        #1;
        iReset = 1'b0;
        sendCommand(AddressTargetId, WaySelectOpcode, 32'h0000_0002, 16'h0000);
        sendCommand(AddressTargetId, ColumnOpcode, 32'h5a5a_1234, 16'h0000);
        sendCommand(AddressTargetId, RowOpcode, 32'hff_abcdef, 16'h0000);
        for (int k = 0; k < NumberOfCommands; k++) begin
            sendCommand(CommandTargetId, CommandOpcodeTable[k], 32'h0, dataLengthT'(16'h0200 + k));
        end
        for (int n = 0; n < RandomCount; n++) begin
            choice    = nextRandom() % 8;
            word      = nextRandom();
            length    = dataLengthT'(nextRandom());
            oneHotWay = '0;
            oneHotWay[nextRandom() % NumberOfWays] = 1'b1;
            case (choice)
                0: begin
                    word[NumberOfWays-1:0] = oneHotWay;
                    sendCommand(AddressTargetId, WaySelectOpcode, word, length);
                end
                1: sendCommand(AddressTargetId, ColumnOpcode, word, length);
                2: sendCommand(AddressTargetId, RowOpcode, word, length);
                6: begin
                    target = targetIdT'(nextRandom());
                    if (target == AddressTargetId || target == CommandTargetId) begin
                        target = 5'd7;
                    end
                    sendCommand(target, opcodeT'(nextRandom()), word, length);
                end
                7: begin
                    opcode = opcodeT'(nextRandom());
                    if (commandIndexOf(opcode) >= 0) begin
                        opcode = 6'd5;   // Not a flash opcode.
                    end
                    sendCommand(CommandTargetId, opcode, word, length);
                end
                default: begin
                    opcode = CommandOpcodeTable[nextRandom() % NumberOfCommands];
                    sendCommand(CommandTargetId, opcode, word, length);
                end
            endcase
        end
        while (!oCommandReady) begin
            @(posedge iSystemClock);
            #1;
        end
        repeat (4) @(posedge iSystemClock);
        if (failureCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: nandCommandIssue.f
logic/nandCommandPkg.sv
logic/commandDispatcher.sv
logic/commandExecutor.sv
logic/atomCommandMux.sv
logic/nandCommandIssue.sv
tb/acgModel.sv
tb/nandCommandIssueTb.sv
